//--- include/obj_defines.svh
// sprite engine sizes
`ifndef OBJ_DEFINES_SVH
`define OBJ_DEFINES_SVH

// sprite table
`define OBJ_ENTRIES 32    // entries in the table
`define OBJ_TBL_AW  7     // byte address, 4 bytes per entry

// per-line resources
`define OBJ_SLOTS   4     // renderers, extra sprites on a line are dropped

// sprite geometry
// square sprites, rows and columns alike
`define OBJ_SIZE    16

// graphics rom
// address is {code, row, word}
// 8 bit code, 4 bit row, 2 bit word of 4 pixels
`define OBJ_ROM_AW  14

`endif

//--- source/obj_screen_pkg.sv
// screen side types
package obj_screen_pkg;

    // line or pixel coordinate, wraps at 256
    typedef logic [7:0] scr_pos_t;

    // one pixel as stored in the line buffer
    // palette goes out as the upper nibble
    typedef struct packed {
        logic [3:0] pal;     // palette select
        logic [3:0] color;   // 0 is transparent
    } obj_pixel_t;

endpackage

//--- source/obj_sprite_pkg.sv
// sprite table types
package obj_sprite_pkg;

    // attribute byte of a table entry
    typedef struct packed {
        logic       rsv7;    // not decoded
        logic       hflip;   // mirror the row
        logic [1:0] rsv54;   // not decoded
        logic [3:0] pal;     // palette select
    } obj_attr_t;

    // one table entry, byte 0 in the low bits
    typedef struct packed {
        obj_attr_t  attr;    // byte 3
        logic [7:0] code;    // byte 2, tile number
        logic [7:0] x;       // byte 1, left edge
        logic [7:0] y;       // byte 0, line of the top row
    } obj_entry_t;

    // what the scanner hands to a slot
    typedef struct packed {
        logic [7:0] x;       // left edge on screen
        logic [7:0] code;    // tile number
        logic [3:0] row;     // row within the sprite
        logic       hflip;
        logic [3:0] pal;
    } obj_load_t;

endpackage

//--- source/obj_scan.sv
// sprite table and line scanner
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_scan
    import obj_screen_pkg::*;
    import obj_sprite_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tbl_we,
    input  logic [`OBJ_TBL_AW-1:0] tbl_addr,
    input  logic [7:0]             tbl_data,
    input  logic                   hinit,
    input  scr_pos_t               v,
    output logic [`OBJ_SLOTS-1:0]  load,
    output obj_load_t              load_data,
    output logic                   scan_done
);

    // table split by byte lane, whole entry read at once
    logic [7:0] tbl_y    [`OBJ_ENTRIES];
    logic [7:0] tbl_x    [`OBJ_ENTRIES];
    logic [7:0] tbl_code [`OBJ_ENTRIES];
    logic [7:0] tbl_attr [`OBJ_ENTRIES];

    logic                            active;    // scan in progress
    logic [$clog2(`OBJ_ENTRIES)-1:0] idx;       // entry under test
    logic [$clog2(`OBJ_SLOTS)-1:0]   slot_idx;  // next free slot
    scr_pos_t                        line_q;    // line being prepared, v+1
    obj_entry_t                      cur;
    logic [7:0]                      diff;
    logic                            visible;

    always_ff @(posedge clk) begin
        if (tbl_we) begin
            case (tbl_addr[1:0])
                2'd0:    tbl_y[tbl_addr[`OBJ_TBL_AW-1:2]]    <= tbl_data;
                2'd1:    tbl_x[tbl_addr[`OBJ_TBL_AW-1:2]]    <= tbl_data;
                2'd2:    tbl_code[tbl_addr[`OBJ_TBL_AW-1:2]] <= tbl_data;
                default: tbl_attr[tbl_addr[`OBJ_TBL_AW-1:2]] <= tbl_data;
            endcase
        end
    end

    assign cur = {tbl_attr[idx], tbl_code[idx], tbl_x[idx], tbl_y[idx]};

    // distance below the sprite top, wraps mod 256
    assign diff    = line_q - cur.y;
    assign visible = active && (diff < `OBJ_SIZE);

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            idx       <= '0;
            slot_idx  <= '0;
            line_q    <= '0;
            load      <= '0;
            scan_done <= 1'b0;
        end else begin
            load      <= '0;    // pulses only
            scan_done <= 1'b0;
            if (hinit) begin
                active   <= 1'b1;
                idx      <= '0;
                slot_idx <= '0;
                line_q   <= v + 8'd1;   // work is for the next line
            end else if (active) begin
                idx <= idx + 1'b1;
                if (visible) begin
                    load[slot_idx] <= 1'b1;
                    slot_idx       <= slot_idx + 1'b1;
                end
                // table end or last slot taken
                if (idx == `OBJ_ENTRIES - 1 ||
                        (visible && slot_idx == `OBJ_SLOTS - 1)) begin
                    active    <= 1'b0;
                    scan_done <= 1'b1;
                end
            end
        end
    end

    // payload goes with the load pulse
    always_ff @(posedge clk) begin
        if (visible) begin
            load_data.x     <= cur.x;
            load_data.code  <= cur.code;
            load_data.row   <= diff[3:0];
            load_data.hflip <= cur.attr.hflip;
            load_data.pal   <= cur.attr.pal;
        end
    end

endmodule

//--- source/obj_slot.sv
// sprite slot renderer
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_slot
    import obj_screen_pkg::*;
    import obj_sprite_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  obj_load_t              load_data,
    output logic                   rom_req,
    output logic [`OBJ_ROM_AW-1:0] rom_addr,
    input  logic                   rom_gnt,
    input  logic [15:0]            rom_data,
    output logic                   pxl_valid,
    output scr_pos_t               pxl_x,
    output obj_pixel_t             pxl_data,
    input  logic                   pxl_pop,
    output logic                   slot_busy
);

    obj_load_t               ld;          // sprite held for this line
    logic [`OBJ_SIZE*4-1:0]  row_q;       // leftmost pixel in the top nibble
    logic [1:0]              req_word;    // word being asked for
    logic [1:0]              fill_cnt;    // words already back
    logic                    gnt_d;       // data from our grant arrives now
    logic [3:0]              pix;         // pixel index 0..15
    logic [3:0]              off;         // screen offset after flip
    logic [8:0]              pos;         // carry marks a wrap past 255

    assign rom_addr = {ld.code, ld.row, req_word};

    always_ff @(posedge clk) begin
        if (reset) begin
            rom_req   <= 1'b0;
            req_word  <= '0;
            fill_cnt  <= '0;
            gnt_d     <= 1'b0;
            pix       <= '0;
            pxl_valid <= 1'b0;
            slot_busy <= 1'b0;
        end else begin
            gnt_d <= rom_gnt;
            if (load) begin
                rom_req   <= 1'b1;
                req_word  <= '0;
                fill_cnt  <= '0;
                pix       <= '0;
                pxl_valid <= 1'b0;
                slot_busy <= 1'b1;
            end else begin
                if (rom_gnt) begin
                    req_word <= req_word + 1'b1;
                    if (req_word == 2'd3)
                        rom_req <= 1'b0;    // whole row requested
                end
                if (gnt_d) begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == 2'd3)
                        pxl_valid <= 1'b1;  // row complete, start offering
                end
                if (pxl_pop && pxl_valid) begin
                    pix <= pix + 1'b1;
                    if (pix == `OBJ_SIZE - 1) begin
                        pxl_valid <= 1'b0;
                        slot_busy <= 1'b0;
                    end
                end
            end
        end
    end

    // sprite payload, no reset
    always_ff @(posedge clk) begin
        if (load)
            ld <= load_data;
        if (gnt_d)
            row_q <= {row_q[`OBJ_SIZE*4-17:0], rom_data};   // word 0 ends on top
        else if (pxl_pop && pxl_valid)
            row_q <= row_q << 4;    // next pixel to the top
    end

    assign off = ld.hflip ? 4'(`OBJ_SIZE - 1) - pix : pix;
    assign pos = {1'b0, ld.x} + {5'd0, off};

    assign pxl_x          = pos[7:0];
    assign pxl_data.pal   = ld.pal;
    assign pxl_data.color = pos[8] ? 4'd0 : row_q[`OBJ_SIZE*4-1 -: 4];  // wrapped ones dropped

endmodule

//--- source/obj_rom_arb.sv
// graphics rom arbiter
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_rom_arb (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`OBJ_SLOTS-1:0]  rom_req,
    input  logic [`OBJ_ROM_AW-1:0] rom_addr_slot [`OBJ_SLOTS],
    output logic [`OBJ_SLOTS-1:0]  rom_gnt,
    output logic [`OBJ_ROM_AW-1:0] obj_addr
);

    logic [`OBJ_SLOTS-1:0]         avail;
    logic [$clog2(`OBJ_SLOTS)-1:0] sel;

    // a slot granted this cycle still shows its old request
    assign avail = rom_req & ~rom_gnt;

    // lowest index wins
    always_comb begin
        sel = '0;
        for (int i = `OBJ_SLOTS - 1; i >= 0; i--) begin
            if (avail[i])
                sel = i[$clog2(`OBJ_SLOTS)-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rom_gnt <= '0;
        end else begin
            rom_gnt <= '0;
            if (|avail)
                rom_gnt[sel] <= 1'b1;   // one grant per cycle
        end
    end

    // address lines up with the grant
    always_ff @(posedge clk) begin
        if (|avail)
            obj_addr <= rom_addr_slot[sel];
    end

endmodule

//--- source/obj_linebuf.sv
// double line buffer
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_linebuf
    import obj_screen_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hinit,
    input  logic [`OBJ_SLOTS-1:0] slot_busy,
    input  logic [`OBJ_SLOTS-1:0] pxl_valid,
    input  scr_pos_t              pxl_x    [`OBJ_SLOTS],
    input  obj_pixel_t            pxl_data [`OBJ_SLOTS],
    output logic [`OBJ_SLOTS-1:0] pxl_pop,
    input  scr_pos_t              h,
    output obj_pixel_t            obj_pxl
);

    obj_pixel_t mem [512];    // {half, x}

    logic                          wr_half;   // half being drawn
    logic                          found;     // some slot still busy
    logic [$clog2(`OBJ_SLOTS)-1:0] cur;       // lowest busy slot
    logic                          take;
    logic                          wr_en;
    logic [8:0]                    wr_addr;
    logic [8:0]                    rd_addr;

    // drain strictly in slot order
    always_comb begin
        found = 1'b0;
        cur   = '0;
        for (int i = 0; i < `OBJ_SLOTS; i++) begin
            if (!found && slot_busy[i]) begin
                found = 1'b1;
                cur   = i[$clog2(`OBJ_SLOTS)-1:0];
            end
        end
    end

    assign take = found && pxl_valid[cur];   // waits while it fetches

    always_comb begin
        pxl_pop      = '0;
        pxl_pop[cur] = take;
    end

    assign wr_addr = {wr_half, pxl_x[cur]};
    assign rd_addr = {~wr_half, h};

    // first opaque pixel keeps the spot
    assign wr_en = take && pxl_data[cur].color != 4'd0 && mem[wr_addr] == '0;

    always_ff @(posedge clk) begin
        if (reset)
            wr_half <= 1'b0;
        else if (hinit)
            wr_half <= ~wr_half;    // halves swap each line
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= pxl_data[cur];
        mem[rd_addr] <= '0;         // clear behind the readout
    end

    always_ff @(posedge clk) begin
        if (reset)
            obj_pxl <= '0;
        else
            obj_pxl <= mem[rd_addr];
    end

endmodule

//--- source/obj_engine.sv
// scanline sprite engine top
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_engine
    import obj_screen_pkg::*;
    import obj_sprite_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // sprite table writes
    input  logic                   tbl_we,
    input  logic [`OBJ_TBL_AW-1:0] tbl_addr,
    input  logic [7:0]             tbl_data,
    // screen timing
    input  logic                   hinit,
    input  scr_pos_t               v,
    input  scr_pos_t               h,
    // graphics rom
    output logic [`OBJ_ROM_AW-1:0] obj_addr,
    input  logic [15:0]            obj_rom_data,
    // pixel out
    output obj_pixel_t             obj_pxl
);

    logic [`OBJ_SLOTS-1:0]  load;
    obj_load_t              load_data;
    logic [`OBJ_SLOTS-1:0]  rom_req;
    logic [`OBJ_SLOTS-1:0]  rom_gnt;
    logic [`OBJ_ROM_AW-1:0] rom_addr_slot [`OBJ_SLOTS];
    logic [`OBJ_SLOTS-1:0]  pxl_valid;
    logic [`OBJ_SLOTS-1:0]  pxl_pop;
    logic [`OBJ_SLOTS-1:0]  slot_busy;
    scr_pos_t               pxl_x    [`OBJ_SLOTS];
    obj_pixel_t             pxl_data [`OBJ_SLOTS];

    // finds the sprites of the next line
    obj_scan u_scan (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .tbl_we    ( tbl_we    ),
        .tbl_addr  ( tbl_addr  ),
        .tbl_data  ( tbl_data  ),
        .hinit     ( hinit     ),
        .v         ( v         ),
        .load      ( load      ),
        .load_data ( load_data ),
        .scan_done (           )   // slots not loaded by now stay empty
    );

    for (genvar i = 0; i < `OBJ_SLOTS; i++) begin : g_slot
        obj_slot u_slot (
            .clk       ( clk              ),
            .reset     ( reset            ),
            .load      ( load[i]          ),
            .load_data ( load_data        ),
            .rom_req   ( rom_req[i]       ),
            .rom_addr  ( rom_addr_slot[i] ),
            .rom_gnt   ( rom_gnt[i]       ),
            .rom_data  ( obj_rom_data     ),   // latched only by the granted slot
            .pxl_valid ( pxl_valid[i]     ),
            .pxl_x     ( pxl_x[i]         ),
            .pxl_data  ( pxl_data[i]      ),
            .pxl_pop   ( pxl_pop[i]       ),
            .slot_busy ( slot_busy[i]     )
        );
    end

    // single rom port shared by the slots
    obj_rom_arb u_arb (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .rom_req       ( rom_req       ),
        .rom_addr_slot ( rom_addr_slot ),
        .rom_gnt       ( rom_gnt       ),
        .obj_addr      ( obj_addr      )
    );

    obj_linebuf u_linebuf (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .hinit     ( hinit     ),
        .slot_busy ( slot_busy ),
        .pxl_valid ( pxl_valid ),
        .pxl_x     ( pxl_x     ),
        .pxl_data  ( pxl_data  ),
        .pxl_pop   ( pxl_pop   ),
        .h         ( h         ),
        .obj_pxl   ( obj_pxl   )
    );

endmodule

//--- test/obj_rom_model.sv
// graphics rom model
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_rom_model (
    input  logic                   clk,
    input  logic [`OBJ_ROM_AW-1:0] addr,
    output logic [15:0]            data
);

    // nibble k counts up from the low address bits
    function automatic logic [15:0] word_at(input logic [`OBJ_ROM_AW-1:0] a);
        logic [15:0] w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            if (a[5:4] != 2'd3)                 // rows 12..15 blank
                w[4*k +: 4] = a[3:0] + 4'(k);
        end
        return w;
    endfunction

    always @(posedge clk) begin
        data <= word_at(addr);    // one cycle latency
    end

endmodule

//--- test/obj_engine_tb.sv
// sprite engine testbench
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_engine_tb
    import obj_screen_pkg::*;
;

    localparam int LINE_CYCLES = 258;   // hinit, 256 reads, last sample
    localparam int MAX_REC     = 64;

    logic                   clk;
    logic                   reset;
    logic                   tbl_we;
    logic [`OBJ_TBL_AW-1:0] tbl_addr;
    logic [7:0]             tbl_data;
    logic                   hinit;
    scr_pos_t               v;
    scr_pos_t               h;
    logic [`OBJ_ROM_AW-1:0] obj_addr;
    logic [15:0]            obj_rom_data;
    obj_pixel_t             obj_pxl;

    logic [47:0] vec [MAX_REC];    // {type, a, b, c, d, e}
    logic [7:0]  ty [32];          // reference copy of the table
    logic [7:0]  tx [32];
    logic [7:0]  tc [32];
    logic [7:0]  ta [32];
    logic [23:0] chk_q [$];        // {line, h, pixel} for the next frame
    logic [`OBJ_ROM_AW-1:0] last_addr;    // rom address at the previous sample
    int          seed;
    int          pix_err;
    int          addr_err;
    int          vec_err;
    int          pix_cnt;
    longint      timeout_ns;

    obj_engine u_dut (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .tbl_we       ( tbl_we       ),
        .tbl_addr     ( tbl_addr     ),
        .tbl_data     ( tbl_data     ),
        .hinit        ( hinit        ),
        .v            ( v            ),
        .h            ( h            ),
        .obj_addr     ( obj_addr     ),
        .obj_rom_data ( obj_rom_data ),
        .obj_pxl      ( obj_pxl      )
    );

    obj_rom_model u_rom (
        .clk  ( clk          ),
        .addr ( obj_addr     ),
        .data ( obj_rom_data )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    // colour of pixel j in a row, straight from the rom rule
    function automatic logic [3:0] rom_color(input logic [7:0] code, input logic [3:0] row,
                                             input int j);
        logic [13:0] a;
        logic [3:0]  k;
        a = {code, row, 2'(j / 4)};
        k = 4'(3 - j % 4);                   // leftmost pixel is the top nibble
        if (a[5:4] == 2'd3)
            return 4'd0;
        return a[3:0] + k;
    endfunction

    // reference pixel of screen line ln at position x
    function automatic logic [7:0] expected_pixel(input logic [7:0] ln, input logic [7:0] x);
        logic [7:0] d;
        logic [8:0] p;
        logic [3:0] c;
        logic [7:0] res;
        int         cnt;
        res = 8'h00;
        cnt = 0;
        for (int n = 0; n < 32; n++) begin
            d = ln - ty[n];
            if (d < 16 && cnt < `OBJ_SLOTS) begin
                cnt++;                       // later sprites dropped
                for (int j = 0; j < 16; j++) begin
                    p = {1'b0, tx[n]} + 9'(ta[n][6] ? 15 - j : j);
                    c = rom_color(tc[n], d[3:0], j);
                    if (p == {1'b0, x} && res == 8'h00 && c != 4'd0)
                        res = {ta[n][3:0], c};   // lower index keeps it
                end
            end
        end
        return res;
    endfunction

    // code and row of a fetch must belong to a sprite shown on line ln
    function automatic bit addr_fits_line(input logic [7:0] ln,
                                          input logic [`OBJ_ROM_AW-1:0] a);
        logic [7:0] d;
        int         cnt;
        bit         ok;
        cnt = 0;
        ok  = 1'b0;
        for (int n = 0; n < 32; n++) begin
            d = ln - ty[n];
            if (d < 16 && cnt < `OBJ_SLOTS) begin
                cnt++;
                if (a[13:6] == tc[n] && a[5:2] == d[3:0])
                    ok = 1'b1;
            end
        end
        return ok;
    endfunction

    task automatic write_byte(input logic [6:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        tbl_we   = 1'b1;
        tbl_addr = addr;
        tbl_data = data;
        case (addr[1:0])
            2'd0:    ty[addr[6:2]] = data;
            2'd1:    tx[addr[6:2]] = data;
            2'd2:    tc[addr[6:2]] = data;
            default: ta[addr[6:2]] = data;
        endcase
        @(posedge clk);
        #2 tbl_we = 1'b0;
    endtask

    // one line period, readout of line vl while line vl+1 is drawn
    task automatic run_line(input logic [7:0] vl, input bit chk, input bit shuffle);
        int         order [256];
        int         j;
        int         t;
        logic [7:0] prev;
        logic [7:0] exp;
        for (int i = 0; i < 256; i++)
            order[i] = i;
        if (shuffle) begin
            for (int i = 255; i > 0; i--) begin
                j = {$random(seed)} % (i + 1);
                t = order[i];
                order[i] = order[j];
                order[j] = t;
            end
        end
        @(posedge clk);
        #2;
        hinit = 1'b1;
        v     = vl;
        for (int i = 0; i <= 256; i++) begin
            @(posedge clk);
            #1;
            if (i > 0 && chk) begin
                exp = expected_pixel(vl, prev);
                pix_cnt++;
                if (obj_pxl !== exp) begin
                    pix_err++;
                    $display("mismatch obj_pxl line %h h %h: got %h expected %h",
                             vl, prev, obj_pxl, exp);
                end
            end
            // a new fetch is always for the line being drawn
            if (obj_addr !== last_addr) begin
                if (!addr_fits_line(vl + 8'd1, obj_addr)) begin
                    addr_err++;
                    $display("mismatch obj_addr line %h: got %h, no sprite row of that line",
                             vl + 8'd1, obj_addr);
                end
                last_addr = obj_addr;
            end
            #1;
            hinit = 1'b0;
            if (i < 256) begin
                prev = 8'(order[i]);
                h    = prev;
            end
        end
    endtask

    task automatic run_frame(input logic [7:0] first, input logic [7:0] last);
        logic [7:0] e;
        bit         hit;
        foreach (chk_q[i]) begin
            e = expected_pixel(chk_q[i][23:16], chk_q[i][15:8]);
            if (e !== chk_q[i][7:0]) begin
                vec_err++;
                $display("vector for line %h h %h disagrees with the table reference",
                         chk_q[i][23:16], chk_q[i][15:8]);
            end
        end
        for (int vl = first - 1; vl <= last; vl++) begin
            hit = 1'b0;
            foreach (chk_q[i])
                if (chk_q[i][23:16] == 8'(vl))
                    hit = 1'b1;
            run_line(8'(vl), vl != first - 1, !hit);   // first line is stale
        end
        chk_q.delete();
    endtask

    initial begin
        int lines;
        int recs;
        reset      = 1'b1;
        tbl_we     = 1'b0;
        tbl_addr   = '0;
        tbl_data   = '0;
        hinit      = 1'b0;
        v          = '0;
        h          = '0;
        seed       = 96;
        pix_err    = 0;
        addr_err   = 0;
        vec_err    = 0;
        pix_cnt    = 0;
        timeout_ns = 0;
        $readmemh("test/obj_vectors.txt", vec);
        lines = 2;          // warm-up lines
        recs  = 0;
        while (recs < MAX_REC && vec[recs][47:40] != 8'h00) begin
            if (vec[recs][47:40] == 8'h03)
                lines += vec[recs][31:24] - vec[recs][39:32] + 2;
            recs++;
        end
        timeout_ns = longint'((lines + 2) * LINE_CYCLES + 2 * (128 + 4 * recs) + 20) * 40;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        // park every entry below the lines used
        for (int a = 0; a < 128; a++)
            write_byte(7'(a), (a % 4 == 0) ? 8'hc8 : 8'h00);
        last_addr = obj_addr;           // no fetch since reset
        run_line(8'hfa, 1'b0, 1'b0);    // both halves cleared
        run_line(8'hfb, 1'b0, 1'b0);
        for (int r = 0; r < recs; r++) begin
            case (vec[r][47:40])
                8'h01: begin                        // whole entry
                    for (int k = 0; k < 4; k++)
                        write_byte({vec[r][36:32], 2'(k)}, vec[r][31 - 8 * k -: 8]);
                end
                8'h02: chk_q.push_back(vec[r][39:16]);
                8'h03: run_frame(vec[r][39:32], vec[r][31:24]);
                8'h04: write_byte(vec[r][38:32], vec[r][31:24]);
                default: begin
                    vec_err++;
                    $display("unknown record type in vector file at record %0d", r);
                end
            endcase
        end
        $display("errors: %0d pixel mismatches, %0d address mismatches, %0d vector errors, %0d pixels checked",
                 pix_err, addr_err, vec_err, pix_cnt);
        if (pix_err == 0 && addr_err == 0 && vec_err == 0 && pix_cnt > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog, limit set once the vectors are counted
    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("timeout: the run did not finish within %0d ns", timeout_ns);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- test/obj_vectors.txt
// type a b c d e: 01 entry n y x code attr, 02 check line h pixel
// 03 frame first last, 04 byte addr data, 00 end
// single sprite, rows 12..15 blank
01_00_14_28_05_03
02_14_28_33_00_00
02_14_2b_00_00_00
02_14_2c_34_00_00
02_13_28_00_00_00
02_1f_28_3f_00_00
02_20_28_00_00_00
03_12_25_00_00_00
// horizontal flip
01_00_14_28_05_43
02_14_37_33_00_00
02_14_28_33_00_00
02_14_34_00_00_00
03_13_15_00_00_00
// overlap, entry 1 shows through gaps
01_01_14_2c_05_05
02_14_34_55_00_00
02_14_33_34_00_00
02_14_38_56_00_00
03_13_15_00_00_00
// six on one line, four shown
01_02_64_00_01_06
01_03_64_14_01_07
01_04_64_28_01_08
01_05_64_3c_01_09
01_06_64_50_01_0a
01_07_64_64_01_0b
02_64_3c_93_00_00
02_64_50_00_00_00
02_64_64_00_00_00
02_64_00_63_00_00
03_63_65_00_00_00
// right edge cut, no wrap
01_08_96_fa_02_0c
02_96_fa_c3_00_00
02_96_ff_c3_00_00
02_96_01_00_00_00
03_95_97_00_00_00
// entry 8 moved away, buffer reads back clear
04_20_c8_00_00_00
02_96_fa_00_00_00
03_95_97_00_00_00
00_00_00_00_00_00

//--- obj_engine.f
+incdir+include
source/obj_screen_pkg.sv
source/obj_sprite_pkg.sv
source/obj_scan.sv
source/obj_slot.sv
source/obj_rom_arb.sv
source/obj_linebuf.sv
source/obj_engine.sv
test/obj_rom_model.sv
test/obj_engine_tb.sv

//--- Bender.yml
package:
  name: obj_engine

export_include_dirs:
  - include

sources:
  - files:
      - source/obj_screen_pkg.sv
      - source/obj_sprite_pkg.sv
      - source/obj_scan.sv
      - source/obj_slot.sv
      - source/obj_rom_arb.sv
      - source/obj_linebuf.sv
      - source/obj_engine.sv
  - target: test
    files:
      - test/obj_rom_model.sv
      - test/obj_engine_tb.sv
